//--- core_defs.svh
// Core sizing macros; the read latency must agree with the fixed stage count in regfile
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data word width in bits
`define CORE_XLEN 32

// Register index width
`define CORE_REG_AW 5

// Number of architectural registers
`define CORE_NREGS 32

// Cycles from read strobe to read data and valid
`define CORE_RD_LAT 3

`endif

//--- rf_pkg.sv
// Register-file storage types only; widths come from the core sizing macros
`include "core_defs.svh"

package rf_pkg;

    // One data word held in a register
    typedef logic [`CORE_XLEN-1:0] word_t;

    // Register index, wide enough for every register
    typedef logic [`CORE_REG_AW-1:0] reg_idx_t;

endpackage

//--- isa_pkg.sv
// Instruction set types; opcode occupies the top four bits of every format
`include "core_defs.svh"

package isa_pkg;
    import rf_pkg::*;

    localparam int OPC_W = 4;
    localparam int IMM_W = `CORE_XLEN - OPC_W - 2 * `CORE_REG_AW;
    localparam int PAD_W = `CORE_XLEN - OPC_W - 3 * `CORE_REG_AW;

    // Codes not listed here are illegal
    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h9,
        OP_ANDI = 4'ha,
        OP_ORI  = 4'hb
    } opcode_t;

    typedef struct packed {
        opcode_t                opcode;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        reg_idx_t               rs2;
        logic [PAD_W-1:0]       unused;
    } r_fmt_t;

    typedef struct packed {
        opcode_t                opcode;
        reg_idx_t               rd;
        reg_idx_t               rs1;
        logic signed [IMM_W-1:0] imm;
    } i_fmt_t;

    // Same word seen as either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // Immediate forms reuse add, and, or
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

endpackage

//--- rf_read_if.sv
// One register-file read port; rdata and rvalid return together CORE_RD_LAT cycles after re
`timescale 1ns/100ps

interface rf_read_if import rf_pkg::*; ();

    logic     re;
    reg_idx_t raddr;
    word_t    rdata;
    logic     rvalid;

    // Issue side drives the request, execute side takes the data
    modport requester (
        output re,
        output raddr,
        input  rdata,
        input  rvalid
    );

    // Storage side answers the request
    modport bank (
        input  re,
        input  raddr,
        output rdata,
        output rvalid
    );

endinterface

//--- regfile.sv
// Register bank with zeroed storage at reset; reads take exactly three cycles, no bypass of writes
`timescale 1ns/100ps
`include "core_defs.svh"

module regfile import rf_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    rf_read_if.bank  rd
);

    word_t    mem [`CORE_NREGS];

    // Stage 1 holds the request
    logic     re_s1;
    reg_idx_t raddr_s1;

    // Stage 2 holds the array output
    logic     vld_s2;
    word_t    data_s2;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            re_s1  <= 1'b0;
            vld_s2 <= 1'b0;
            rd.rvalid <= 1'b0;
        end else begin
            re_s1  <= rd.re;
            vld_s2 <= re_s1;
            rd.rvalid <= vld_s2;
        end
    end

    always_ff @(posedge clock) begin
        raddr_s1 <= rd.raddr;
    end

    // Array read only for a live request
    always_ff @(posedge clock) begin
        if (re_s1) begin
            data_s2 <= mem[raddr_s1];
        end
    end

    // Output register travels with rvalid
    always_ff @(posedge clock) begin
        rd.rdata <= data_s2;
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Data and valid leave together, a fixed latency after the strobe
    a_read_latency: assert property (
        @(posedge clock) disable iff (!resetn)
        rd.rvalid == $past(rd.re, `CORE_RD_LAT)
    );

endmodule

//--- issue_decode.sv
// Issue stage without forwarding or stall; pending writes and illegal opcodes are refused via reject
`timescale 1ns/100ps
`include "core_defs.svh"

module issue_decode import rf_pkg::*, isa_pkg::*; (
    input  logic          clock,
    input  logic          resetn,
    input  logic          instr_valid,
    input  instr_u        instr,
    input  logic          wb_en,
    input  reg_idx_t      wb_idx,
    rf_read_if.requester  rs1_rd,
    rf_read_if.requester  rs2_rd,
    output logic          reject,
    output logic          iss_valid,
    output logic          iss_use_imm,
    output alu_op_t       iss_op,
    output reg_idx_t      iss_rd,
    output word_t         iss_imm
);

    // One bit per register with a write in flight
    logic [`CORE_NREGS-1:0] pending;

    opcode_t  opcode;
    reg_idx_t rd_idx;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    logic     legal;
    logic     use_imm;
    alu_op_t  alu_op;
    logic     hazard;
    logic     accept;

    // Opcode, rd and rs1 share bit positions in both views
    assign opcode  = instr.r.opcode;
    assign rd_idx  = instr.r.rd;
    assign rs1_idx = instr.r.rs1;
    assign rs2_idx = instr.r.rs2;

    always_comb begin
        legal   = 1'b1;
        use_imm = 1'b0;
        alu_op  = ALU_ADD;
        case (opcode)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_ADDI: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
            end
            OP_ANDI: begin
                alu_op  = ALU_AND;
                use_imm = 1'b1;
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                use_imm = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Registered bits, so a same-cycle clear still blocks
    assign hazard = pending[rd_idx] | pending[rs1_idx] | (!use_imm & pending[rs2_idx]);
    assign accept = instr_valid & legal & !hazard;

    // Both banks are read for every accepted instruction
    assign rs1_rd.re    = accept;
    assign rs1_rd.raddr = rs1_idx;
    assign rs2_rd.re    = accept;
    assign rs2_rd.raddr = rs2_idx;

    assign iss_valid   = accept;
    assign iss_use_imm = use_imm;
    assign iss_op      = alu_op;
    assign iss_rd      = rd_idx;
    assign iss_imm     = {{(`CORE_XLEN - IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            pending <= '0;
            reject  <= 1'b0;
        end else begin
            reject <= instr_valid & !accept;
            if (wb_en) begin
                pending[wb_idx] <= 1'b0;
            end
            if (accept) begin
                pending[rd_idx] <= 1'b1;
            end
        end
    end

    // No accepted source is the target of an issue still in flight
    for (genvar k = 1; k <= `CORE_RD_LAT + 1; k++) begin : g_raw_chk
        a_no_pending_src: assert property (
            @(posedge clock) disable iff (!resetn)
            iss_valid && $past(iss_valid, k) |->
                $past(iss_rd, k) != rs1_idx &&
                (iss_use_imm || $past(iss_rd, k) != rs2_idx)
        );
    end

endmodule

//--- alu_writeback.sv
// Execute and write-back; operation pipe depth is tied to the bank read latency, results in order
`timescale 1ns/100ps
`include "core_defs.svh"

module alu_writeback import rf_pkg::*, isa_pkg::*; (
    input  logic          clock,
    input  logic          resetn,
    input  logic          iss_valid,
    input  logic          iss_use_imm,
    input  alu_op_t       iss_op,
    input  reg_idx_t      iss_rd,
    input  word_t         iss_imm,
    rf_read_if.requester  rs1_rd,
    rf_read_if.requester  rs2_rd,
    output logic          we,
    output reg_idx_t      waddr,
    output word_t         wdata
);

    localparam int DEPTH = `CORE_RD_LAT;
    localparam int LAST  = DEPTH - 1;

    logic [DEPTH-1:0] vld_q;
    alu_op_t          op_q      [DEPTH];
    reg_idx_t         rd_q      [DEPTH];
    word_t            imm_q     [DEPTH];
    logic             use_imm_q [DEPTH];

    word_t            opnd_b;
    word_t            result;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[DEPTH-2:0], iss_valid};
        end
    end

    // Operation details follow valid down the pipe
    always_ff @(posedge clock) begin
        op_q[0]      <= iss_op;
        rd_q[0]      <= iss_rd;
        imm_q[0]     <= iss_imm;
        use_imm_q[0] <= iss_use_imm;
        for (int i = 1; i < DEPTH; i++) begin
            op_q[i]      <= op_q[i-1];
            rd_q[i]      <= rd_q[i-1];
            imm_q[i]     <= imm_q[i-1];
            use_imm_q[i] <= use_imm_q[i-1];
        end
    end

    assign opnd_b = use_imm_q[LAST] ? imm_q[LAST] : rs2_rd.rdata;

    // Arithmetic wraps at the word width
    always_comb begin
        case (op_q[LAST])
            ALU_ADD: result = rs1_rd.rdata + opnd_b;
            ALU_SUB: result = rs1_rd.rdata - opnd_b;
            ALU_AND: result = rs1_rd.rdata & opnd_b;
            ALU_OR:  result = rs1_rd.rdata | opnd_b;
            ALU_XOR: result = rs1_rd.rdata ^ opnd_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            we <= 1'b0;
        end else begin
            we <= vld_q[LAST];
        end
    end

    always_ff @(posedge clock) begin
        if (vld_q[LAST]) begin
            waddr <= rd_q[LAST];
            wdata <= result;
        end
    end

    // Pipe end and both bank outputs agree every cycle
    a_operand_align: assert property (
        @(posedge clock) disable iff (!resetn)
        vld_q[LAST] == rs1_rd.rvalid && vld_q[LAST] == rs2_rd.rvalid
    );

endmodule

//--- exec_core.sv
// Execution core top; fixed four-cycle issue to write-back, reject is the only flow control
`timescale 1ns/100ps
`include "core_defs.svh"

module exec_core import rf_pkg::*, isa_pkg::*; (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  instr_valid,
    input  logic [`CORE_XLEN-1:0] instr,
    output logic                  reject,
    output logic                  wb_valid,
    output reg_idx_t              wb_addr,
    output word_t                 wb_data
);

    // Write port shared by both banks
    logic     we;
    reg_idx_t waddr;
    word_t    wdata;

    logic     iss_valid;
    logic     iss_use_imm;
    alu_op_t  iss_op;
    reg_idx_t iss_rd;
    word_t    iss_imm;

    rf_read_if rs1_port ();
    rf_read_if rs2_port ();

    issue_decode u_issue (
        .clock       (clock),
        .resetn      (resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (we),
        .wb_idx      (waddr),
        .rs1_rd      (rs1_port),
        .rs2_rd      (rs2_port),
        .reject      (reject),
        .iss_valid   (iss_valid),
        .iss_use_imm (iss_use_imm),
        .iss_op      (iss_op),
        .iss_rd      (iss_rd),
        .iss_imm     (iss_imm)
    );

    // Mirrored banks, one per source operand
    regfile bank_rs1 (
        .clock   (clock),
        .resetn  (resetn),
        .wr_en   (we),
        .wr_addr (waddr),
        .wr_data (wdata),
        .rd      (rs1_port)
    );

    regfile bank_rs2 (
        .clock   (clock),
        .resetn  (resetn),
        .wr_en   (we),
        .wr_addr (waddr),
        .wr_data (wdata),
        .rd      (rs2_port)
    );

    alu_writeback u_alu (
        .clock       (clock),
        .resetn      (resetn),
        .iss_valid   (iss_valid),
        .iss_use_imm (iss_use_imm),
        .iss_op      (iss_op),
        .iss_rd      (iss_rd),
        .iss_imm     (iss_imm),
        .rs1_rd      (rs1_port),
        .rs2_rd      (rs2_port),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata)
    );

    // Every write is reported
    assign wb_valid = we;
    assign wb_addr  = waddr;
    assign wb_data  = wdata;

endmodule

//--- tb_exec_core.sv
// Directed testbench for exec_core; register r0 is only ever written with zero, so it stays the readback base
`timescale 1ns/100ps

module tb_exec_core;

    localparam logic [3:0] OPC_ADD  = 4'h1;
    localparam logic [3:0] OPC_SUB  = 4'h2;
    localparam logic [3:0] OPC_AND  = 4'h3;
    localparam logic [3:0] OPC_OR   = 4'h4;
    localparam logic [3:0] OPC_XOR  = 4'h5;
    localparam logic [3:0] OPC_ADDI = 4'h9;
    localparam logic [3:0] OPC_ANDI = 4'ha;
    localparam logic [3:0] OPC_ORI  = 4'hb;
    localparam int WB_TIMEOUT = 10;

    logic        clock = 1'b0;
    logic        resetn;
    logic        instr_valid;
    logic [31:0] instr;
    logic        reject;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // Reference register contents
    logic [31:0] model [32];
    integer      seed;
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;

    exec_core dut (
        .clock       (clock),
        .resetn      (resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .reject      (reject),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] r_type_word(input logic [3:0] op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        return {op, rd, rs1, rs2, 13'd0};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [3:0] op, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [17:0] imm);
        return {op, rd, rs1, imm};
    endfunction

    // Expected result from the reference registers
    function automatic logic [31:0] predict(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        a   = model[w[22:18]];
        b   = model[w[17:13]];
        imm = {{14{w[17]}}, w[17:0]};
        case (w[31:28])
            OPC_ADD:  return a + b;
            OPC_SUB:  return a - b;
            OPC_AND:  return a & b;
            OPC_OR:   return a | b;
            OPC_XOR:  return a ^ b;
            OPC_ADDI: return a + imm;
            OPC_ANDI: return a & imm;
            OPC_ORI:  return a | imm;
            default:  return '0;
        endcase
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Holds the word for one cycle and returns that cycle's number
    task automatic drive(input logic [31:0] w, output int ic);
        @(posedge clock);
        instr_valid <= 1'b1;
        instr       <= w;
        @(negedge clock);
        ic = cycle;
    endtask

    task automatic idle();
        @(posedge clock);
        instr_valid <= 1'b0;
        instr       <= '0;
    endtask

    task automatic expect_wb(input logic [4:0] addr, input logic [31:0] data, input int ic);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!wb_valid && waited < WB_TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!wb_valid) begin
            errors++;
            $display("ERROR: no write-back to r%0d within %0d cycles", addr, WB_TIMEOUT);
            finish_run();
        end else begin
            compare("latency", cycle - ic, 32'd4);
            compare("wb_addr", wb_addr, addr);
            compare("wb_data", wb_data, data);
            model[addr] = data;
        end
    endtask

    // Issue one instruction alone and see it through
    task automatic run_one(input logic [31:0] w, input logic exp_rej);
        int          ic;
        logic [31:0] exp_data;
        exp_data = predict(w);
        drive(w, ic);
        idle();
        @(negedge clock);
        compare("reject", reject, exp_rej);
        if (exp_rej) begin
            repeat (6) begin
                @(negedge clock);
                compare("wb_valid", wb_valid, 32'd0);
            end
        end else begin
            expect_wb(w[27:23], exp_data, ic);
        end
    endtask

    // Upper 18 bits, 14 doublings, then OR in the low 14 bits
    task automatic load_reg(input logic [4:0] idx, input logic [31:0] value);
        run_one(i_type_word(OPC_ADDI, idx, 5'd0, value[31:14]), 1'b0);
        repeat (14) run_one(r_type_word(OPC_ADD, idx, idx, idx), 1'b0);
        run_one(i_type_word(OPC_ORI, idx, idx, {4'd0, value[13:0]}), 1'b0);
    endtask

    task automatic reset_add_check();
        @(negedge clock);
        compare("reject", reject, 32'd0);
        compare("wb_valid", wb_valid, 32'd0);
        run_one(r_type_word(OPC_ADD, 5'd3, 5'd1, 5'd2), 1'b0);
    endtask

    task automatic immediate_ops();
        run_one(i_type_word(OPC_ADDI, 5'd1, 5'd0, 18'd1234), 1'b0);
        run_one(i_type_word(OPC_ADDI, 5'd2, 5'd0, -18'sd5), 1'b0);
        run_one(i_type_word(OPC_ADDI, 5'd4, 5'd2, 18'h20000), 1'b0);
        run_one(i_type_word(OPC_ANDI, 5'd5, 5'd2, 18'h20f0f), 1'b0);
        run_one(i_type_word(OPC_ORI, 5'd6, 5'd1, 18'h10000), 1'b0);
        run_one(i_type_word(OPC_ORI, 5'd7, 5'd0, 18'h3ffff), 1'b0);
    endtask

    task automatic r_format_ops();
        for (int k = 1; k <= 4; k++) begin
            load_reg(k[4:0], $random(seed));
        end
        run_one(r_type_word(OPC_ADD, 5'd10, 5'd1, 5'd2), 1'b0);
        run_one(r_type_word(OPC_SUB, 5'd11, 5'd1, 5'd2), 1'b0);
        run_one(r_type_word(OPC_AND, 5'd12, 5'd3, 5'd4), 1'b0);
        run_one(r_type_word(OPC_OR, 5'd13, 5'd3, 5'd4), 1'b0);
        run_one(r_type_word(OPC_XOR, 5'd14, 5'd1, 5'd4), 1'b0);
        // Zero minus a value wraps
        run_one(r_type_word(OPC_SUB, 5'd15, 5'd0, 5'd3), 1'b0);
    endtask

    task automatic back_to_back_issue();
        logic [31:0] words [4];
        logic [31:0] exp   [4];
        int          ic    [4];
        words[0] = r_type_word(OPC_ADD, 5'd20, 5'd1, 5'd2);
        words[1] = r_type_word(OPC_SUB, 5'd21, 5'd3, 5'd4);
        words[2] = r_type_word(OPC_XOR, 5'd22, 5'd1, 5'd3);
        words[3] = i_type_word(OPC_ORI, 5'd23, 5'd2, 18'h00155);
        for (int k = 0; k < 4; k++) begin
            exp[k] = predict(words[k]);
        end
        for (int k = 0; k < 4; k++) begin
            drive(words[k], ic[k]);
            compare("reject", reject, 32'd0);
        end
        idle();
        for (int k = 0; k < 4; k++) begin
            expect_wb(words[k][27:23], exp[k], ic[k]);
            // Last word's reject shows in the first write-back cycle
            if (k == 0) begin
                compare("reject", reject, 32'd0);
            end
        end
    endtask

    task automatic hazard_reject();
        logic [31:0] producer;
        logic [31:0] blocked [4];
        logic [31:0] exp5;
        logic [31:0] exp6;
        int          ic;
        producer   = i_type_word(OPC_ADDI, 5'd5, 5'd1, 18'h00777);
        exp5       = predict(producer);
        // Source rs1, source rs2, destination, then rs1 again as the write lands
        blocked[0] = r_type_word(OPC_ADD, 5'd6, 5'd5, 5'd2);
        blocked[1] = r_type_word(OPC_ADD, 5'd6, 5'd2, 5'd5);
        blocked[2] = i_type_word(OPC_ADDI, 5'd5, 5'd2, 18'd1);
        blocked[3] = r_type_word(OPC_ADD, 5'd6, 5'd5, 5'd2);
        drive(producer, ic);
        for (int k = 0; k < 4; k++) begin
            drive(blocked[k], ic);
            compare("reject", reject, k >= 1);
            compare("wb_valid", wb_valid, k == 3);
            if (k == 3) begin
                compare("wb_addr", wb_addr, 32'd5);
                compare("wb_data", wb_data, exp5);
                model[5] = exp5;
            end
        end
        exp6 = predict(blocked[3]);
        drive(blocked[3], ic);
        compare("reject", reject, 32'd1);
        compare("wb_valid", wb_valid, 32'd0);
        idle();
        @(negedge clock);
        compare("reject", reject, 32'd0);
        compare("wb_valid", wb_valid, 32'd0);
        expect_wb(5'd6, exp6, ic);
    endtask

    task automatic illegal_opcode();
        run_one(r_type_word(4'h0, 5'd1, 5'd2, 5'd3), 1'b1);
        run_one(i_type_word(4'h7, 5'd3, 5'd1, 18'h00042), 1'b1);
        run_one(i_type_word(4'hf, 5'd20, 5'd0, 18'h3ffff), 1'b1);
        // Read every register back unchanged
        for (int k = 0; k < 32; k++) begin
            run_one(r_type_word(OPC_ADD, k[4:0], k[4:0], 5'd0), 1'b0);
        end
    endtask

    initial begin
        resetn      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'h8f39_46a8;
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
        repeat (4) @(posedge clock);
        resetn <= 1'b1;
        reset_add_check();
        immediate_ops();
        r_format_ops();
        back_to_back_issue();
        hazard_reject();
        illegal_opcode();
        finish_run();
    end

endmodule

//--- compile.f
+incdir+.
rf_pkg.sv
isa_pkg.sv
rf_read_if.sv
regfile.sv
issue_decode.sv
alu_writeback.sv
exec_core.sv
tb_exec_core.sv
